//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dual_issue
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv sim/*.sv sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+sim
verilog/dual_issue_pkg.sv
verilog/reg_file.sv
verilog/operand_bypass.sv
verilog/exe_alu.sv
verilog/exe_mul.sv
verilog/issue_exe.sv
verilog/exe_stage.sv
verilog/dual_issue_top.sv
sim/tb_dual_issue.sv

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] arch_regs [32];

task automatic model_reset();
    foreach (arch_regs[i]) arch_regs[i] = '0;
endtask

function automatic logic [31:0] model_op(
    input dual_issue_pkg::alu_op_e op,
    input logic [31:0]             a,
    input logic [31:0]             b
);
    case (op)
        dual_issue_pkg::OP_ADD: return a + b;
        dual_issue_pkg::OP_SUB: return a - b;
        dual_issue_pkg::OP_AND: return a & b;
        dual_issue_pkg::OP_OR:  return a | b;
        dual_issue_pkg::OP_XOR: return a ^ b;
        dual_issue_pkg::OP_SLL: return a << b[4:0];
        dual_issue_pkg::OP_SRL: return a >> b[4:0];
        dual_issue_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        dual_issue_pkg::OP_MUL: return a * b;              // Low half only
        default:                return '0;
    endcase
endfunction

function automatic dual_issue_pkg::wb_lane_t expected_wb(input dual_issue_pkg::issue_slot_t s);
    dual_issue_pkg::wb_lane_t w;
    logic [31:0]              a;
    logic [31:0]              b;
    a       = arch_regs[s.rs1];
    b       = s.use_imm ? s.imm : arch_regs[s.rs2];
    w.valid = 1'b1;
    w.pc    = s.pc;
    w.rd    = s.rd;
    w.rf_we = s.rf_we;
    w.value = model_op(s.op, a, b);
    return w;
endfunction

task automatic commit_result(input dual_issue_pkg::wb_lane_t w);
    if (w.rf_we && (w.rd != 5'd0)) arch_regs[w.rd] = w.value;   // r0 stays zero
endtask

`endif

//--- sim/tb_dual_issue.sv
`timescale 1ns/1ns

module tb_dual_issue;

    localparam int MUL_CYCLES  = 3;
    localparam int N_INIT      = 16;
    localparam int N_RAND      = 400;
    localparam int WATCHDOG_NS = (N_INIT + N_RAND) * (MUL_CYCLES + 2) * 100 + 5000;

    logic                        clk;
    logic                        rstn;
    dual_issue_pkg::issue_slot_t set1;
    dual_issue_pkg::issue_slot_t set2;
    logic                        flush;
    logic                        o_ready;
    dual_issue_pkg::wb_lane_t    o_retire_a;
    dual_issue_pkg::wb_lane_t    o_retire_b;

    logic [31:0]                 rng_state = 32'ha821_5217;
    logic [31:0]                 pc_next   = 32'h0000_1000;
    int                          stall_left;
    dual_issue_pkg::wb_lane_t    exp_q [$];    // Program order
    int                          pair_size_q [$];
    logic [4:0]                  recent [$];

    `include "tb_model.svh"

    dual_issue_top #(.MUL_CYCLES(MUL_CYCLES)) UUT (
        .clk (clk), .rstn (rstn), .i_set1 (set1), .i_set2 (set2), .i_flush (flush),
        .o_ready (o_ready), .o_retire_a (o_retire_a), .o_retire_b (o_retire_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the pipeline did not retire every pair within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_wb(input string name, input dual_issue_pkg::wb_lane_t got,
                            input dual_issue_pkg::wb_lane_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: o_ready got %b expected %b", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Search only the oldest pair since lanes may be swapped
    task automatic match_one(input string name, input dual_issue_pkg::wb_lane_t got,
                             input int limit);
        int idx;
        idx = -1;
        for (int i = 0; i < limit && i < exp_q.size(); i++) begin
            if (exp_q[i].pc == got.pc) idx = i;
        end
        if (idx < 0) begin
            $display("%s retired pc %h, which is not in the oldest waiting pair", name, got.pc);
            stop_with_failure();
        end else begin
            check_wb(name, got, exp_q[idx]);
            exp_q.delete(idx);
        end
    endtask

    task automatic sample_outputs();
        int n_seen;
        int n_exp;
        check_ready(o_ready, stall_left == 0);
        if (stall_left > 0) stall_left--;
        n_seen = int'(o_retire_a.valid) + int'(o_retire_b.valid);
        if (n_seen != 0) begin
            if (pair_size_q.size() == 0) begin
                $display("a retirement appeared while no accepted pair was waiting");
                stop_with_failure();
            end else begin
                n_exp = pair_size_q.pop_front();
                if (n_seen != n_exp) begin
                    $display("a pair retired %0d results in one cycle instead of %0d",
                             n_seen, n_exp);
                    stop_with_failure();
                end
                if (o_retire_a.valid) match_one("o_retire_a", o_retire_a, n_exp);
                if (o_retire_b.valid) match_one("o_retire_b", o_retire_b, n_exp - n_seen + 1);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % 32'(n));
    endfunction

    function automatic logic [4:0] pick_src(input logic [4:0] avoid);
        logic [4:0] r;
        if ((recent.size() > 0) && (rand_below(2) == 0)) r = recent[rand_below(recent.size())];
        else r = 5'(rand_below(32));
        if ((r == avoid) && (avoid != 5'd0)) r = r + 5'd1;
        return r;
    endfunction

    task automatic make_slot(input logic is_mul, input logic [4:0] avoid,
                             output dual_issue_pkg::issue_slot_t s);
        s         = '0;
        s.valid   = 1'b1;
        s.cls     = is_mul ? dual_issue_pkg::CLS_MUL : dual_issue_pkg::CLS_ALU;
        s.op      = is_mul ? dual_issue_pkg::OP_MUL : dual_issue_pkg::alu_op_e'(4'(rand_below(8)));
        s.rs1     = pick_src(avoid);
        s.rs2     = pick_src(avoid);
        s.rd      = (rand_below(8) == 0) ? 5'd0 : 5'(rand_below(32));
        s.rf_we   = rand_below(8) != 0;
        s.use_imm = rand_below(4) == 0;
        s.imm     = next_rand();
    endtask

    task automatic make_random_pair(output dual_issue_pkg::issue_slot_t s1,
                                    output dual_issue_pkg::issue_slot_t s2);
        logic mul1;
        logic mul2;
        mul1 = rand_below(5) == 0;
        mul2 = !mul1 && (rand_below(5) == 0);   // One multiply at most
        make_slot(mul1, 5'd0, s1);
        make_slot(mul2, s1.rd, s2);
        if (s2.rd == s1.rd) s2.rd = s2.rd + 5'd1;
        if (rand_below(8) == 0) s2 = '0;        // Single issue
        s1.pc   = pc_next;
        s2.pc   = pc_next + 32'd4;
        pc_next = pc_next + 32'd8;
        recent.push_back(s1.rd);
        if (s2.valid) recent.push_back(s2.rd);
        while (recent.size() > 4) recent.delete(0);
    endtask

    task automatic accept_pair(input dual_issue_pkg::issue_slot_t s1,
                               input dual_issue_pkg::issue_slot_t s2);
        dual_issue_pkg::wb_lane_t w;
        int                       n;
        n = 0;
        if (s1.valid) begin
            w = expected_wb(s1);
            exp_q.push_back(w);
            commit_result(w);
            n++;
        end
        if (s2.valid) begin
            w = expected_wb(s2);
            exp_q.push_back(w);
            commit_result(w);
            n++;
        end
        pair_size_q.push_back(n);
        if ((s1.valid && (s1.cls == dual_issue_pkg::CLS_MUL)) ||
            (s2.valid && (s2.cls == dual_issue_pkg::CLS_MUL))) begin
            stall_left = MUL_CYCLES - 1;
        end
    endtask

    // Called right after a rising edge and returns at the accepting edge
    task automatic present_pair(input dual_issue_pkg::issue_slot_t s1,
                                input dual_issue_pkg::issue_slot_t s2, input logic fl);
        logic rdy;
        set1  <= s1;
        set2  <= s2;
        flush <= fl;
        rdy   = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            sample_outputs();
            rdy = o_ready;
            @(posedge clk);
        end
        if (!fl) accept_pair(s1, s2);
    endtask

    initial begin
        dual_issue_pkg::issue_slot_t s1;
        dual_issue_pkg::issue_slot_t s2;
        set1       = '0;
        set2       = '0;
        flush      = 1'b0;
        rstn       = 1'b0;
        stall_left = 0;
        model_reset();
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_ready(o_ready, 1'b1);
        check_flag("o_retire_a.valid", o_retire_a.valid, 1'b0);
        check_flag("o_retire_b.valid", o_retire_b.valid, 1'b0);
        @(posedge clk);
        for (int k = 0; k < N_INIT; k++) begin     // Load every register from r0 + imm
            s1 = '0;
            s1.valid   = 1'b1;
            s1.rf_we   = 1'b1;
            s1.use_imm = 1'b1;
            s2 = s1;
            s1.rd  = 5'(2 * k + 1);
            s2.rd  = 5'(2 * k + 2);
            s1.imm = next_rand();
            s2.imm = next_rand();
            s1.pc  = pc_next;
            s2.pc  = pc_next + 32'd4;
            pc_next = pc_next + 32'd8;
            present_pair(s1, s2, 1'b0);
        end
        for (int k = 0; k < N_RAND; k++) begin
            make_random_pair(s1, s2);
            present_pair(s1, s2, rand_below(16) == 0);
        end
        set1  <= '0;
        set2  <= '0;
        flush <= 1'b0;
        while (pair_size_q.size() != 0) begin
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
        end
        repeat (MUL_CYCLES + 4) begin               // Nothing may retire twice
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- verilog/dual_issue_pkg.sv
package dual_issue_pkg;

    parameter int XLEN = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and instruction classes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SLT = 4'd7,          // Signed compare
        OP_MUL = 4'd8           // Low half of unsigned product
    } alu_op_e;

    typedef enum logic {
        CLS_ALU = 1'b0,
        CLS_MUL = 1'b1
    } inst_class_e;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [31:0]     pc;
        inst_class_e     cls;
        alu_op_e         op;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            rf_we;
        logic            use_imm;   // Source 2 taken from imm
        logic [XLEN-1:0] imm;
    } issue_slot_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     pc;
        inst_class_e     cls;
        alu_op_e         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [4:0]      rd;
        logic            rf_we;
    } ex_lane_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     pc;
        logic [4:0]      rd;
        logic            rf_we;
        logic [XLEN-1:0] value;
    } wb_lane_t;

endpackage

//--- verilog/dual_issue_top.sv
`timescale 1ns/1ns

module dual_issue_top #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  dual_issue_pkg::issue_slot_t i_set1,
    input  dual_issue_pkg::issue_slot_t i_set2,
    input  logic                        i_flush,
    output logic                        o_ready,
    output dual_issue_pkg::wb_lane_t    o_retire_a,
    output dual_issue_pkg::wb_lane_t    o_retire_b
);

    logic [4:0]                      rf_raddr [4];
    logic [dual_issue_pkg::XLEN-1:0] rf_rdata [4];
    logic [dual_issue_pkg::XLEN-1:0] src      [4];
    dual_issue_pkg::ex_lane_t        lane_a;
    dual_issue_pkg::ex_lane_t        lane_b;
    dual_issue_pkg::ex_lane_t        ex_a;
    dual_issue_pkg::ex_lane_t        ex_b;
    dual_issue_pkg::wb_lane_t        wb_a;
    dual_issue_pkg::wb_lane_t        wb_b;
    logic                            stall;

    assign rf_raddr[0] = i_set1.rs1;
    assign rf_raddr[1] = i_set1.rs2;
    assign rf_raddr[2] = i_set2.rs1;
    assign rf_raddr[3] = i_set2.rs2;

    assign o_ready    = !stall;
    assign o_retire_a = wb_a;
    assign o_retire_b = wb_b;

    reg_file u_rf (.clk(clk), .i_raddr(rf_raddr), .o_rdata(rf_rdata), .i_wb_a(wb_a), .i_wb_b(wb_b));

    operand_bypass u_bypass (
        .i_set1 (i_set1), .i_set2 (i_set2), .i_rf_rdata (rf_rdata),
        .i_ex_a (ex_a),   .i_ex_b (ex_b),
        .i_wb_a (wb_a),   .i_wb_b (wb_b),   .o_src (src)
    );

    issue_exe u_issue (
        .clk (clk), .rstn (rstn), .i_set1 (i_set1), .i_set2 (i_set2), .i_src (src),
        .i_flush (i_flush), .i_stall (stall), .o_lane_a (lane_a), .o_lane_b (lane_b)
    );

    exe_stage #(.MUL_CYCLES(MUL_CYCLES)) u_exe (
        .clk (clk), .rstn (rstn), .i_lane_a (lane_a), .i_lane_b (lane_b),
        .o_ex_a (ex_a), .o_ex_b (ex_b), .o_wb_a (wb_a), .o_wb_b (wb_b), .o_stall (stall)
    );

endmodule

//--- verilog/exe_alu.sv
`timescale 1ns/1ns

module exe_alu (
    input  dual_issue_pkg::alu_op_e         i_op,
    input  logic [dual_issue_pkg::XLEN-1:0] i_a,
    input  logic [dual_issue_pkg::XLEN-1:0] i_b,
    output logic [dual_issue_pkg::XLEN-1:0] o_y
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            dual_issue_pkg::OP_ADD: o_y = i_a + i_b;
            dual_issue_pkg::OP_SUB: o_y = i_a - i_b;
            dual_issue_pkg::OP_AND: o_y = i_a & i_b;
            dual_issue_pkg::OP_OR:  o_y = i_a | i_b;
            dual_issue_pkg::OP_XOR: o_y = i_a ^ i_b;
            dual_issue_pkg::OP_SLL: o_y = i_a << shamt;
            dual_issue_pkg::OP_SRL: o_y = i_a >> shamt;   // Logical
            dual_issue_pkg::OP_SLT: begin
                o_y = {{(dual_issue_pkg::XLEN-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            end
            default: o_y = '0;                            // Multiply handled elsewhere
        endcase
    end

endmodule

//--- verilog/exe_mul.sv
`timescale 1ns/1ns

module exe_mul #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_start,
    input  logic [dual_issue_pkg::XLEN-1:0] i_a,
    input  logic [dual_issue_pkg::XLEN-1:0] i_b,
    output logic                            o_busy,
    output logic                            o_done,
    output logic [dual_issue_pkg::XLEN-1:0] o_y
);

    localparam int CNT_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(MUL_CYCLES - 1);

    logic [CNT_W-1:0]                cnt;
    logic [dual_issue_pkg::XLEN-1:0] prod;

    assign prod   = i_a * i_b;                  // Low 32 bits only
    assign o_done = i_start && (cnt == LAST);
    assign o_busy = i_start && !o_done;
    assign o_y    = prod;                       // Operands held while busy

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (o_done) begin
            cnt <= '0;                          // Ready for back-to-back multiply
        end else if (i_start) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- verilog/exe_stage.sv
`timescale 1ns/1ns

module exe_stage #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  dual_issue_pkg::ex_lane_t i_lane_a,
    input  dual_issue_pkg::ex_lane_t i_lane_b,
    output dual_issue_pkg::ex_lane_t o_ex_a,
    output dual_issue_pkg::ex_lane_t o_ex_b,
    output dual_issue_pkg::wb_lane_t o_wb_a,
    output dual_issue_pkg::wb_lane_t o_wb_b,
    output logic                     o_stall
);

    logic [dual_issue_pkg::XLEN-1:0] alu_a_y;
    logic [dual_issue_pkg::XLEN-1:0] alu_b_y;
    logic [dual_issue_pkg::XLEN-1:0] mul_y;
    logic [dual_issue_pkg::XLEN-1:0] res_b;
    logic                            is_mul;
    logic                            mul_busy;
    logic                            mul_done;

    exe_alu u_alu_a (.i_op(i_lane_a.op), .i_a(i_lane_a.src1), .i_b(i_lane_a.src2), .o_y(alu_a_y));
    exe_alu u_alu_b (.i_op(i_lane_b.op), .i_a(i_lane_b.src1), .i_b(i_lane_b.src2), .o_y(alu_b_y));

    assign is_mul = i_lane_b.valid && (i_lane_b.cls == dual_issue_pkg::CLS_MUL);

    exe_mul #(.MUL_CYCLES(MUL_CYCLES)) u_mul (
        .clk     (clk),
        .rstn    (rstn),
        .i_start (is_mul),
        .i_a     (i_lane_b.src1),
        .i_b     (i_lane_b.src2),
        .o_busy  (mul_busy),
        .o_done  (mul_done),
        .o_y     (mul_y)
    );

    assign res_b   = is_mul ? mul_y : alu_b_y;
    assign o_stall = mul_busy;

    // Bypass view with src1 replaced by the result
    always_comb begin
        o_ex_a       = i_lane_a;
        o_ex_a.src1  = alu_a_y;
        o_ex_b       = i_lane_b;
        o_ex_b.src1  = res_b;
        o_ex_b.valid = i_lane_b.valid && (!is_mul || mul_done);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_wb_a.valid <= 1'b0;
            o_wb_b.valid <= 1'b0;
        end else begin
            o_wb_a <= '{valid: i_lane_a.valid && !mul_busy, pc: i_lane_a.pc, rd: i_lane_a.rd,
                        rf_we: i_lane_a.rf_we, value: alu_a_y};
            o_wb_b <= '{valid: i_lane_b.valid && !mul_busy, pc: i_lane_b.pc, rd: i_lane_b.rd,
                        rf_we: i_lane_b.rf_we, value: res_b};
        end
    end

endmodule

//--- verilog/issue_exe.sv
`timescale 1ns/1ns

module issue_exe (
    input  logic                            clk,
    input  logic                            rstn,
    input  dual_issue_pkg::issue_slot_t     i_set1,
    input  dual_issue_pkg::issue_slot_t     i_set2,
    input  logic [dual_issue_pkg::XLEN-1:0] i_src [4],
    input  logic                            i_flush,
    input  logic                            i_stall,
    output dual_issue_pkg::ex_lane_t        o_lane_a,
    output dual_issue_pkg::ex_lane_t        o_lane_b
);

    dual_issue_pkg::ex_lane_t lane1;
    dual_issue_pkg::ex_lane_t lane2;
    logic                     swap;

    function automatic dual_issue_pkg::ex_lane_t to_lane(
        input dual_issue_pkg::issue_slot_t     s,
        input logic [dual_issue_pkg::XLEN-1:0] a,
        input logic [dual_issue_pkg::XLEN-1:0] b,
        input logic                            kill
    );
        dual_issue_pkg::ex_lane_t l;
        l.valid = s.valid && !kill;
        l.pc    = s.pc;
        l.cls   = s.cls;
        l.op    = s.op;
        l.src1  = a;
        l.src2  = b;
        l.rd    = s.rd;
        l.rf_we = s.rf_we;
        return l;
    endfunction

    assign lane1 = to_lane(i_set1, i_src[0], i_src[1], i_flush);
    assign lane2 = to_lane(i_set2, i_src[2], i_src[3], i_flush);

    // Multiply in slot 1 moves to lane B
    assign swap = i_set1.valid && (i_set1.cls == dual_issue_pkg::CLS_MUL);

    ////////////////////////////////////////////////////////////////////////////
    // Execute registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_lane_a.valid <= 1'b0;
            o_lane_b.valid <= 1'b0;
        end else if (!i_stall) begin
            if (swap) begin
                o_lane_a <= lane2;
                o_lane_b <= lane1;
            end else begin
                o_lane_a <= lane1;
                o_lane_b <= lane2;
            end
        end
    end

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass (
    input  dual_issue_pkg::issue_slot_t     i_set1,
    input  dual_issue_pkg::issue_slot_t     i_set2,
    input  logic [dual_issue_pkg::XLEN-1:0] i_rf_rdata [4],
    input  dual_issue_pkg::ex_lane_t        i_ex_a,
    input  dual_issue_pkg::ex_lane_t        i_ex_b,
    input  dual_issue_pkg::wb_lane_t        i_wb_a,
    input  dual_issue_pkg::wb_lane_t        i_wb_b,
    output logic [dual_issue_pkg::XLEN-1:0] o_src [4]
);

    logic [4:0] addr [4];

    function automatic logic ex_hit(input dual_issue_pkg::ex_lane_t l, input logic [4:0] a);
        return l.valid && l.rf_we && (l.rd != 5'd0) && (l.rd == a);
    endfunction

    function automatic logic wb_hit(input dual_issue_pkg::wb_lane_t l, input logic [4:0] a);
        return l.valid && l.rf_we && (l.rd != 5'd0) && (l.rd == a);
    endfunction

    assign addr[0] = i_set1.rs1;
    assign addr[1] = i_set1.rs2;
    assign addr[2] = i_set2.rs1;
    assign addr[3] = i_set2.rs2;

    // Later assignments win, so execute beats writeback beats the RF
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            o_src[i] = i_rf_rdata[i];
            if (wb_hit(i_wb_b, addr[i])) o_src[i] = i_wb_b.value;
            if (wb_hit(i_wb_a, addr[i])) o_src[i] = i_wb_a.value;
            if (ex_hit(i_ex_b, addr[i])) o_src[i] = i_ex_b.src1;   // src1 carries result
            if (ex_hit(i_ex_a, addr[i])) o_src[i] = i_ex_a.src1;
        end
        if (i_set1.use_imm) o_src[1] = i_set1.imm;
        if (i_set2.use_imm) o_src[3] = i_set2.imm;
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                            clk,
    input  logic [4:0]                      i_raddr [4],
    output logic [dual_issue_pkg::XLEN-1:0] o_rdata [4],
    input  dual_issue_pkg::wb_lane_t        i_wb_a,
    input  dual_issue_pkg::wb_lane_t        i_wb_b
);

    logic [dual_issue_pkg::XLEN-1:0] regs [32];
    logic                            we_a;
    logic                            we_b;

    assign we_a = i_wb_a.valid && i_wb_a.rf_we && (i_wb_a.rd != 5'd0);
    assign we_b = i_wb_b.valid && i_wb_b.rf_we && (i_wb_b.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (we_a) begin
            regs[i_wb_a.rd] <= i_wb_a.value;
        end
        if (we_b) begin
            regs[i_wb_b.rd] <= i_wb_b.value;   // Pair never shares rd
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            o_rdata[i] = (i_raddr[i] == 5'd0) ? '0 : regs[i_raddr[i]];   // r0 reads zero
        end
    end

endmodule
